/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_1000

// instruction queue entries
`define RV_IQ_DEPTH 8

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

`endif

/* design/rv_isa_pkg.sv */
`include "rv_consts.svh"

package rv_isa_pkg;

    // major opcodes the core executes
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_t;

    // funct3 field of OP and OP-IMM
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_t;

    // alu operation selected at decode
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // register index
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

endpackage

/* design/rv_pipe_pkg.sv */
`include "rv_consts.svh"

package rv_pipe_pkg;

    // wishbone classic, read-only master side
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [`RV_XLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_rsp_t;

    // one fetched word with its program position
    typedef struct packed {
        logic [`RV_XLEN-1:0] order;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } fetch_pkt_t;

    // issue register contents
    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  order;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  inst;
        rv_isa_pkg::alu_op_t  alu_op;
        logic [`RV_XLEN-1:0]  op_a;
        logic [`RV_XLEN-1:0]  op_b;
        rv_isa_pkg::reg_idx_t rd;
        logic                 rd_we;
    } issue_pkt_t;

    // result register contents
    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  order;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  inst;
        rv_isa_pkg::reg_idx_t rd;
        logic                 rd_we;
        logic [`RV_XLEN-1:0]  rd_data;
    } result_t;

    // external retire record
    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  order;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  inst;
        rv_isa_pkg::reg_idx_t rd;
        logic                 rd_we;
        logic [`RV_XLEN-1:0]  rd_data;
    } retire_t;

endpackage

/* design/fetch_unit.sv */
`include "rv_consts.svh"

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  rv_pipe_pkg::wb_rsp_t          wb_rsp_i,
    output rv_pipe_pkg::wb_req_t          wb_req_o,
    input  logic [$clog2(`RV_IQ_DEPTH):0] iq_count_i,
    output logic                          push_o,
    output rv_pipe_pkg::fetch_pkt_t       pkt_o
);

    localparam int CNT_W = $clog2(`RV_IQ_DEPTH) + 1;

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] order_q;
    logic                req_q;
    logic                ack;
    logic [CNT_W:0]      slots_needed;
    logic                room;

    assign ack = req_q && wb_rsp_i.ack;

    // queue entries in use once the pending push and the next word land
    assign slots_needed = {1'b0, iq_count_i} + {{CNT_W{1'b0}}, push_o} + (CNT_W + 1)'(1);
    assign room         = slots_needed <= (CNT_W + 1)'(`RV_IQ_DEPTH);

    assign wb_req_o.cyc = req_q;
    assign wb_req_o.stb = req_q;
    assign wb_req_o.adr = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `RV_RESET_PC;
            order_q <= '0;
            req_q   <= 1'b0;
            push_o  <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (ack) begin
                // drop cyc for a cycle, push the word next cycle
                req_q   <= 1'b0;
                push_o  <= 1'b1;
                pc_q    <= pc_q + `RV_XLEN'(4);
                order_q <= order_q + `RV_XLEN'(1);
            end else if (!req_q && room) begin
                req_q <= 1'b1;
            end
        end
    end

    // fetched word, valid alongside push_o
    always_ff @(posedge clk) begin
        if (ack) begin
            pkt_o <= '{order: order_q, pc: pc_q, inst: wb_rsp_i.dat};
        end
    end

endmodule

/* design/inst_queue.sv */
`include "rv_consts.svh"

module inst_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push_i,
    input  rv_pipe_pkg::fetch_pkt_t       pkt_i,
    input  logic                          pop_i,
    output rv_pipe_pkg::fetch_pkt_t       head_o,
    output logic                          empty_o,
    output logic [$clog2(`RV_IQ_DEPTH):0] count_o
);

    localparam int PTR_W = $clog2(`RV_IQ_DEPTH);

    rv_pipe_pkg::fetch_pkt_t mem [`RV_IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`RV_IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= pkt_i;
        end
    end

    // fall-through head
    assign head_o  = mem[rd_ptr];
    assign empty_o = count == '0;
    assign count_o = count;

endmodule

/* design/decode_issue.sv */
`include "rv_consts.svh"

module decode_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pipe_pkg::fetch_pkt_t head_i,
    input  logic                    empty_i,
    output logic                    pop_o,
    output rv_isa_pkg::reg_idx_t    rs1_addr_o,
    output rv_isa_pkg::reg_idx_t    rs2_addr_o,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output rv_pipe_pkg::issue_pkt_t issue_o
);

    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_u;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::alu_op_t  alu_op;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 known;
    logic                 hazard;

    // funct3 to alu op, bit 30 picks sub and sra
    function automatic rv_isa_pkg::alu_op_t alu_op_of(input rv_isa_pkg::funct3_t f3,
                                                       input logic alt, input logic is_reg);
        case (f3)
            rv_isa_pkg::f3_add_sub: return (is_reg && alt) ? rv_isa_pkg::alu_sub
                                                           : rv_isa_pkg::alu_add;
            rv_isa_pkg::f3_sll:     return rv_isa_pkg::alu_sll;
            rv_isa_pkg::f3_slt:     return rv_isa_pkg::alu_slt;
            rv_isa_pkg::f3_sltu:    return rv_isa_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:     return rv_isa_pkg::alu_xor;
            rv_isa_pkg::f3_srl_sra: return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            rv_isa_pkg::f3_or:      return rv_isa_pkg::alu_or;
            default:                return rv_isa_pkg::alu_and;
        endcase
    endfunction

    assign rs1_addr_o = head_i.inst[19:15];
    assign rs2_addr_o = head_i.inst[24:20];
    assign rd         = head_i.inst[11:7];
    assign funct3     = rv_isa_pkg::funct3_t'(head_i.inst[14:12]);
    assign imm_i      = {{(`RV_XLEN - 12){head_i.inst[31]}}, head_i.inst[31:20]};
    assign imm_u      = {head_i.inst[31:12], 12'b0};

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        known   = 1'b1;
        alu_op  = rv_isa_pkg::alu_add;
        op_a    = rs1_data_i;
        op_b    = rs2_data_i;
        case (head_i.inst[6:0])
            rv_isa_pkg::op_imm: begin
                use_rs1 = 1'b1;
                alu_op  = alu_op_of(funct3, head_i.inst[30], 1'b0);
                op_b    = imm_i;
            end
            rv_isa_pkg::op_reg: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alu_op  = alu_op_of(funct3, head_i.inst[30], 1'b1);
            end
            rv_isa_pkg::op_lui: begin
                alu_op = rv_isa_pkg::alu_pass_b;
                op_a   = '0;
                op_b   = imm_u;
            end
            rv_isa_pkg::op_auipc: begin
                op_a = head_i.pc;
                op_b = imm_u;
            end
            default: begin
                // retires without a register write
                known = 1'b0;
            end
        endcase
    end

    // source still in the issue register, its result reaches the bypass next cycle
    assign hazard = issue_o.valid && issue_o.rd_we
                    && ((use_rs1 && rs1_addr_o == issue_o.rd)
                        || (use_rs2 && rs2_addr_o == issue_o.rd));

    assign pop_o = !empty_i && !hazard;

    // a stall or an empty queue loads a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_o.valid <= 1'b0;
        end else begin
            issue_o <= '{valid:  pop_o,
                         order:  head_i.order,
                         pc:     head_i.pc,
                         inst:   head_i.inst,
                         alu_op: alu_op,
                         op_a:   op_a,
                         op_b:   op_b,
                         rd:     rd,
                         rd_we:  known && (rd != '0)};
        end
    end

endmodule

/* design/alu_exec.sv */
`include "rv_consts.svh"

module alu_exec (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pipe_pkg::issue_pkt_t issue_i,
    output rv_pipe_pkg::result_t    result_o
);

    logic [`RV_XLEN-1:0]         a;
    logic [`RV_XLEN-1:0]         b;
    logic [$clog2(`RV_XLEN)-1:0] shamt;
    logic [`RV_XLEN-1:0]         res;

    assign a     = issue_i.op_a;
    assign b     = issue_i.op_b;
    assign shamt = b[$clog2(`RV_XLEN)-1:0];

    always_comb begin
        case (issue_i.alu_op)
            rv_isa_pkg::alu_add:    res = a + b;
            rv_isa_pkg::alu_sub:    res = a - b;
            rv_isa_pkg::alu_sll:    res = a << shamt;
            rv_isa_pkg::alu_slt:    res = {{(`RV_XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            rv_isa_pkg::alu_sltu:   res = {{(`RV_XLEN - 1){1'b0}}, a < b};
            rv_isa_pkg::alu_xor:    res = a ^ b;
            rv_isa_pkg::alu_srl:    res = a >> shamt;
            rv_isa_pkg::alu_sra:    res = $unsigned($signed(a) >>> shamt);
            rv_isa_pkg::alu_or:     res = a | b;
            rv_isa_pkg::alu_and:    res = a & b;
            rv_isa_pkg::alu_pass_b: res = b;
            default:                res = a + b;
        endcase
    end

    // result register, fields ride along with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            result_o.valid <= 1'b0;
        end else begin
            result_o <= '{valid:   issue_i.valid,
                          order:   issue_i.order,
                          pc:      issue_i.pc,
                          inst:    issue_i.inst,
                          rd:      issue_i.rd,
                          rd_we:   issue_i.rd_we,
                          rd_data: res};
        end
    end

endmodule

/* design/reg_writeback.sv */
`include "rv_consts.svh"

module reg_writeback (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pipe_pkg::result_t result_i,
    input  rv_isa_pkg::reg_idx_t rs1_addr_i,
    input  rv_isa_pkg::reg_idx_t rs2_addr_i,
    output logic [`RV_XLEN-1:0]  rs1_data_o,
    output logic [`RV_XLEN-1:0]  rs2_data_o,
    output rv_pipe_pkg::retire_t retire_o
);

    // x1 to x31 only, x0 is hardwired
    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];
    logic                wr_en;

    assign wr_en = result_i.valid && result_i.rd_we;

    always_ff @(posedge clk) begin
        if (!rst && wr_en) begin
            regs[result_i.rd] <= result_i.rd_data;
        end
    end

    // write-through so a read in the write cycle sees the new value
    function automatic logic [`RV_XLEN-1:0] read_port(input rv_isa_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && result_i.rd == addr) begin
            return result_i.rd_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // retire record, rd data only shown when written
    assign retire_o.valid   = result_i.valid;
    assign retire_o.order   = result_i.order;
    assign retire_o.pc      = result_i.pc;
    assign retire_o.inst    = result_i.inst;
    assign retire_o.rd      = result_i.rd;
    assign retire_o.rd_we   = result_i.rd_we;
    assign retire_o.rd_data = result_i.rd_we ? result_i.rd_data : '0;

endmodule

/* design/rv_core_top.sv */
`include "rv_consts.svh"

module rv_core_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pipe_pkg::wb_rsp_t wb_rsp_i,
    output rv_pipe_pkg::wb_req_t wb_req_o,
    output rv_pipe_pkg::retire_t retire_o
);

    localparam int CNT_W = $clog2(`RV_IQ_DEPTH) + 1;

    // fetch to queue
    logic                    iq_push;
    rv_pipe_pkg::fetch_pkt_t iq_pkt;
    logic [CNT_W-1:0]        iq_count;

    // queue to decode
    rv_pipe_pkg::fetch_pkt_t iq_head;
    logic                    iq_empty;
    logic                    iq_pop;

    // register file reads
    rv_isa_pkg::reg_idx_t    rs1_addr;
    rv_isa_pkg::reg_idx_t    rs2_addr;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;

    rv_pipe_pkg::issue_pkt_t issue;
    rv_pipe_pkg::result_t    result;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .wb_rsp_i   (wb_rsp_i),
        .wb_req_o   (wb_req_o),
        .iq_count_i (iq_count),
        .push_o     (iq_push),
        .pkt_o      (iq_pkt)
    );

    inst_queue u_iq (
        .clk     (clk),
        .rst     (rst),
        .push_i  (iq_push),
        .pkt_i   (iq_pkt),
        .pop_i   (iq_pop),
        .head_o  (iq_head),
        .empty_o (iq_empty),
        .count_o (iq_count)
    );

    decode_issue u_decode (
        .clk        (clk),
        .rst        (rst),
        .head_i     (iq_head),
        .empty_i    (iq_empty),
        .pop_o      (iq_pop),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .issue_o    (issue)
    );

    alu_exec u_alu (
        .clk      (clk),
        .rst      (rst),
        .issue_i  (issue),
        .result_o (result)
    );

    reg_writeback u_wb (
        .clk        (clk),
        .rst        (rst),
        .result_i   (result),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .retire_o   (retire_o)
    );

endmodule

/* tb/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// what one instruction should leave on the retire port
typedef struct packed {
    logic                rd_we;
    logic [`RV_XLEN-1:0] rd_data;
} expect_t;

logic [31:0] lfsr_state;

// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// opcodes the core does not execute
function automatic logic [6:0] unsupported_opcode(input logic [1:0] sel);
    case (sel)
        2'd0:    return 7'b0000011;
        2'd1:    return 7'b0100011;
        2'd2:    return 7'b1100011;
        default: return 7'b1101111;
    endcase
endfunction

task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [2:0]  kind;
    logic [24:0] junk;
    lfsr_state = 32'hf23f;
    for (int k = 0; k < N; k++) begin
        rd    = 5'(take_bits(2));
        rs1   = 5'(take_bits(2));
        rs2   = 5'(take_bits(2));
        f3    = 3'(take_bits(3));
        alt   = take_bits(1) != 0;
        imm   = 12'(take_bits(12));
        upper = 20'(take_bits(20));
        kind  = 3'(take_bits(3));
        if (k < 3) begin
            // addi x1..x3, x0, imm so no register is read before it is written
            prog[k] = {imm, 5'd0, 3'b000, 5'(k + 1), 7'b0010011};
        end else if (take_bits(4) == 0) begin
            junk    = 25'(take_bits(25));
            prog[k] = {junk, unsupported_opcode(2'(take_bits(2)))};
        end else if (kind <= 3'd2) begin
            if (f3 == 3'b001) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            prog[k] = {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind <= 3'd5) begin
            prog[k] = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                       rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind == 3'd6) begin
            prog[k] = {upper, rd, 7'b0110111};
        end else begin
            prog[k] = {upper, rd, 7'b0010111};
        end
    end
endtask

// rv32i semantics of one instruction, a and b are the source register values
function automatic expect_t ref_execute(input logic [31:0] inst, input logic [31:0] pc,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] opnd;
    logic [31:0] val;
    logic        kept;
    logic        we;
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'b0};
    kept  = 1'b1;
    val   = '0;
    case (inst[6:0])
        7'b0010011, 7'b0110011: begin
            opnd = (inst[6:0] == 7'b0110011) ? b : imm_i;
            case (inst[14:12])
                3'b000:  val = (inst[5] && inst[30]) ? a - opnd : a + opnd;
                3'b001:  val = a << opnd[4:0];
                3'b010:  val = ($signed(a) < $signed(opnd)) ? 32'd1 : 32'd0;
                3'b011:  val = (a < opnd) ? 32'd1 : 32'd0;
                3'b100:  val = a ^ opnd;
                3'b101:  val = inst[30] ? 32'($signed(a) >>> opnd[4:0]) : a >> opnd[4:0];
                3'b110:  val = a | opnd;
                default: val = a & opnd;
            endcase
        end
        7'b0110111: val = imm_u;
        7'b0010111: val = pc + imm_u;
        default:    kept = 1'b0;
    endcase
    we = kept && (inst[11:7] != 5'd0);
    return '{rd_we: we, rd_data: we ? val : 32'd0};
endfunction

`endif

/* tb/tb_rv_core.sv */
`include "rv_consts.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N              = 200;
    localparam int TIMEOUT_CYCLES = N * 8 + 100;

    logic                 clk;
    logic                 rst;
    rv_pipe_pkg::wb_rsp_t wb_rsp;
    rv_pipe_pkg::wb_req_t wb_req;
    rv_pipe_pkg::retire_t retire;

    logic [31:0] prog [N];
    logic [31:0] shadow [32];
    int          retire_count;
    int          cycle_count;
    int          mismatch_count;
    int          failure_count;

    // memory model state
    logic        in_req;
    logic [31:0] req_adr;
    logic [31:0] next_adr;
    int          wait_left;

    `include "rv_ref_model.svh"

    rv_core_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_rsp_i (wb_rsp),
        .wb_req_o (wb_req),
        .retire_o (retire)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("mismatch at %0d ns: %s expected %h actual %h", $time, name, want, got);
        mismatch_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        failure_count++;
    endtask

    task automatic finish_run();
        if (retire_count < N) begin
            report_failure($sformatf("%0d of %0d instructions never retired",
                                     N - retire_count, N));
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // wishbone classic slave with 0 to 3 wait cycles
    always @(negedge clk) begin : wb_memory
        logic [31:0] off;
        if (wb_rsp.ack) begin
            wb_rsp   = '0;
            in_req   = 1'b0;
            next_adr = next_adr + 32'd4;
            assert (wb_req.cyc === 1'b0 && wb_req.stb === 1'b0)
            else report_failure("cyc or stb still high in the cycle after ack");
        end else if (wb_req.cyc === 1'b1) begin
            assert (wb_req.stb === 1'b1)
            else report_failure("cyc raised without stb");
            if (!in_req) begin
                in_req    = 1'b1;
                req_adr   = wb_req.adr;
                wait_left = int'(take_bits(2));
                assert (wb_req.adr === next_adr)
                else report_mismatch("wb_req_o.adr", next_adr, wb_req.adr);
            end else begin
                assert (wb_req.adr === req_adr)
                else report_mismatch("wb_req_o.adr held", req_adr, wb_req.adr);
            end
            off = wb_req.adr - `RV_RESET_PC;
            if (wait_left > 0) begin
                wait_left--;
            end else if (off[1:0] == 2'b00 && off < 32'(4 * N)) begin
                // past the program there is no ack, so the core goes idle
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = prog[off >> 2];
            end
        end else begin
            // cyc stays up until the ack
            assert (!in_req)
            else report_failure("cyc dropped before ack");
            in_req = 1'b0;
        end
    end

    // compare each retire against the reference
    always @(negedge clk) begin : compare_retire
        logic [31:0] inst;
        logic [31:0] pc;
        expect_t     want;
        if (retire.valid === 1'b1) begin
            if (retire_count >= N) begin
                report_failure("retire beyond the end of the program");
            end else begin
                inst = prog[retire_count];
                pc   = `RV_RESET_PC + 32'(4 * retire_count);
                want = ref_execute(inst, pc, shadow[inst[19:15]], shadow[inst[24:20]]);
                assert (retire.order === 32'(retire_count))
                else report_mismatch("retire_o.order", 32'(retire_count), retire.order);
                assert (retire.pc === pc)
                else report_mismatch("retire_o.pc", pc, retire.pc);
                assert (retire.inst === inst)
                else report_mismatch("retire_o.inst", inst, retire.inst);
                assert (retire.rd === inst[11:7])
                else report_mismatch("retire_o.rd", 32'(inst[11:7]), 32'(retire.rd));
                assert (retire.rd_we === want.rd_we)
                else report_mismatch("retire_o.rd_we", 32'(want.rd_we), 32'(retire.rd_we));
                assert (retire.rd_data === want.rd_data)
                else report_mismatch("retire_o.rd_data", want.rd_data, retire.rd_data);
                if (want.rd_we) begin
                    shadow[inst[11:7]] = want.rd_data;
                end
            end
            retire_count++;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        finish_run();
    end

    initial begin : main_flow
        clk            = 1'b0;
        rst            = 1'b1;
        wb_rsp         = '0;
        in_req         = 1'b0;
        req_adr        = '0;
        next_adr       = `RV_RESET_PC;
        wait_left      = 0;
        retire_count   = 0;
        mismatch_count = 0;
        failure_count  = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        build_program();

        // bus and retire quiet throughout reset
        repeat (10) begin
            @(negedge clk);
            assert (wb_req.cyc === 1'b0 && wb_req.stb === 1'b0)
            else report_failure("wishbone request active during reset");
            assert (retire.valid === 1'b0)
            else report_failure("retire valid during reset");
        end
        rst = 1'b0;

        // first fetch goes out one cycle after reset
        @(negedge clk);
        assert (retire.valid === 1'b0)
        else report_failure("retire valid right after reset");
        assert (wb_req.cyc === 1'b1)
        else report_failure("no fetch request in the first cycle after reset");
        assert (wb_req.adr === `RV_RESET_PC)
        else report_mismatch("wb_req_o.adr", `RV_RESET_PC, wb_req.adr);

        wait (retire_count >= N);
        // quiet tail to catch duplicate retires
        repeat (20) @(negedge clk);
        finish_run();
    end

endmodule

/* all.f */
+incdir+design
+incdir+tb
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/decode_issue.sv
design/alu_exec.sv
design/reg_writeback.sv
design/rv_core_top.sv
tb/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_pipe_pkg.sv
      - design/fetch_unit.sv
      - design/inst_queue.sv
      - design/decode_issue.sv
      - design/alu_exec.sv
      - design/reg_writeback.sv
      - design/rv_core_top.sv
  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/tb_rv_core.sv
